// File: logic/dcache_geom_pkg.sv
package dcache_geom_pkg;

    // organisation of the cache
    localparam int NUM_SETS       = 8;
    localparam int NUM_WAYS       = 4;
    localparam int SET_BITS       = 3;
    localparam int OFFSET_BITS    = 5;   // 32-byte lines
    localparam int TAG_BITS       = 32 - SET_BITS - OFFSET_BITS;

    // data widths
    localparam int WORD_BITS      = 32;
    localparam int LINE_BITS      = 256;
    localparam int BEATS_PER_LINE = LINE_BITS / WORD_BITS;

    // memory burst length field, beats minus one
    localparam int BURST_LEN      = BEATS_PER_LINE - 1;

    // address fields
    typedef logic [TAG_BITS-1:0]            tag_t;
    typedef logic [SET_BITS-1:0]            set_idx_t;
    typedef logic [OFFSET_BITS-3:0]         word_idx_t;

    // one bit per way
    typedef logic [NUM_WAYS-1:0]            way_mask_t;

    // payload
    typedef logic [WORD_BITS-1:0]           word_t;
    typedef logic [WORD_BITS/8-1:0]         strb_t;
    typedef logic [LINE_BITS-1:0]           line_t;

endpackage

// File: logic/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

    // controller states
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_TAG_READ,
        ST_CACHE_READ,
        ST_EVICT,
        ST_MEM_WRITE,    // write-back request
        ST_SEND,         // write-back beats
        ST_MEM_READ,     // refill request
        ST_RECEIVE,      // refill beats
        ST_REFILL,
        ST_CACHE_WRITE,
        ST_RESPONSE
    } cache_state_e;

    // cpu request opcode, same encoding as the port bit
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

endpackage

// File: logic/dcache_arrays.sv
`timescale 1ns/1ps

module dcache_arrays import dcache_geom_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  set_idx_t  set_idx,
    input  tag_t      tag,
    input  word_idx_t word_idx,
    input  way_mask_t sel_way,
    input  logic      fill_en,
    input  line_t     fill_line,
    input  logic      word_wr_en,
    input  word_t     wdata,
    input  strb_t     wstrb,
    input  logic      clean_en,
    output way_mask_t hit_mask,
    output way_mask_t valid_mask,
    output way_mask_t dirty_mask,
    output line_t     sel_line,
    output word_t     sel_word,
    output tag_t      sel_tag
);

    way_mask_t valid_q [NUM_SETS];
    way_mask_t dirty_q [NUM_SETS];
    tag_t      tag_q   [NUM_SETS][NUM_WAYS];
    line_t     data_q  [NUM_SETS][NUM_WAYS];

    word_t     merged_word;

    // status bits per set
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (fill_en) begin
                valid_q[set_idx] <= valid_q[set_idx] | sel_way;
            end
            if (word_wr_en) begin
                dirty_q[set_idx] <= dirty_q[set_idx] | sel_way;
            end else if (clean_en) begin
                dirty_q[set_idx] <= dirty_q[set_idx] & ~sel_way;   // line now matches memory
            end
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (sel_way[w]) begin
                if (fill_en) begin
                    tag_q[set_idx][w]  <= tag;
                    data_q[set_idx][w] <= fill_line;
                end else if (word_wr_en) begin
                    data_q[set_idx][w][word_idx*WORD_BITS +: WORD_BITS] <= merged_word;
                end
            end
        end
    end

    // tag compare across the set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_mask[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == tag);
        end
    end

    assign valid_mask = valid_q[set_idx];
    assign dirty_mask = valid_q[set_idx] & dirty_q[set_idx];

    // and-or mux on the selected way
    always_comb begin
        sel_line = '0;
        sel_tag  = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (sel_way[w]) begin
                sel_line = sel_line | data_q[set_idx][w];
                sel_tag  = sel_tag | tag_q[set_idx][w];
            end
        end
    end

    assign sel_word = sel_line[word_idx*WORD_BITS +: WORD_BITS];

    // byte merge over the old word
    always_comb begin
        merged_word = sel_word;
        for (int b = 0; b < WORD_BITS/8; b++) begin
            if (wstrb[b]) merged_word[b*8 +: 8] = wdata[b*8 +: 8];
        end
    end

    // every write names exactly one way
    a_sel_way_onehot: assert property (
        @(posedge clk) disable iff (rst)
        (fill_en || word_wr_en || clean_en) |-> $onehot(sel_way)
    );

endmodule

// File: logic/dcache_plru.sv
`timescale 1ns/1ps

module dcache_plru import dcache_geom_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  set_idx_t  set_idx,
    input  way_mask_t valid_mask,
    input  logic      touch_en,
    input  way_mask_t touch_way,
    output way_mask_t victim_way
);

    // bit 0 picks the half, bit 1 the lower pair, bit 2 the upper pair
    logic [NUM_WAYS-2:0] tree_q [NUM_SETS];

    logic [NUM_WAYS-2:0] tree;
    logic [1:0]          tree_idx;
    way_mask_t           invalid_way;
    logic                low_pair;

    assign tree     = tree_q[set_idx];
    assign tree_idx = {tree[0], tree[0] ? tree[2] : tree[1]};
    assign low_pair = |touch_way[1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) tree_q[s] <= '0;
        end else if (touch_en) begin
            tree_q[set_idx][0] <= low_pair;   // point at the other half
            if (low_pair) tree_q[set_idx][1] <= touch_way[0];
            else          tree_q[set_idx][2] <= touch_way[2];
        end
    end

    // lowest invalid way wins
    always_comb begin
        invalid_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_mask[w]) invalid_way = way_mask_t'(1) << w;
        end
    end

    assign victim_way = (&valid_mask) ? (way_mask_t'(1) << tree_idx) : invalid_way;

    a_victim_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot(victim_way)
    );

endmodule

// File: logic/dcache_line_buffer.sv
`timescale 1ns/1ps

module dcache_line_buffer import dcache_geom_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rx_active,
    input  logic  mem_rd_rsp_valid,
    input  word_t mem_rd_rsp_data,
    input  logic  load_en,
    input  line_t load_line,
    input  logic  tx_active,
    input  logic  mem_wr_data_ready,
    output line_t fill_line,
    output word_t mem_wr_data,
    output logic  mem_wr_data_last,
    output logic  send_done
);

    line_t                     rx_line_q;
    line_t                     tx_line_q;
    logic [BEATS_PER_LINE-1:0] beat_q;      // one-hot, bit 0 marks the last beat

    logic                      tx_fire;

    assign tx_fire = tx_active && mem_wr_data_ready;

    // refill: new beats enter at the top, word 0 ends at the bottom
    always_ff @(posedge clk) begin
        if (rx_active && mem_rd_rsp_valid) begin
            rx_line_q <= {mem_rd_rsp_data, rx_line_q[LINE_BITS-1:WORD_BITS]};
        end
    end

    assign fill_line = rx_line_q;

    // write-back data shifter
    always_ff @(posedge clk) begin
        if (load_en) begin
            tx_line_q <= load_line;
        end else if (tx_fire) begin
            tx_line_q <= {{WORD_BITS{1'b0}}, tx_line_q[LINE_BITS-1:WORD_BITS]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q <= '0;
        end else if (load_en) begin
            beat_q <= {1'b1, {(BEATS_PER_LINE-1){1'b0}}};
        end else if (tx_fire) begin
            beat_q <= beat_q >> 1;
        end
    end

    assign mem_wr_data      = tx_line_q[WORD_BITS-1:0];
    assign mem_wr_data_last = beat_q[0];
    assign send_done        = tx_fire && beat_q[0];

    // reloading mid-burst would corrupt the write-back
    a_no_load_during_tx: assert property (
        @(posedge clk) disable iff (rst) !(load_en && tx_active)
    );

endmodule

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_geom_pkg::*, dcache_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_req_valid,
    input  logic        cpu_req_op,
    input  logic [31:0] cpu_req_addr,
    input  word_t       cpu_req_wdata,
    input  strb_t       cpu_req_wstrb,
    input  logic        cpu_rsp_ready,
    input  logic        mem_rd_req_ready,
    input  logic        mem_rd_rsp_valid,
    input  logic        mem_rd_rsp_last,
    input  logic        mem_wr_req_ready,
    input  way_mask_t   hit_mask,
    input  way_mask_t   dirty_mask,
    input  way_mask_t   victim_way,
    input  tag_t        sel_tag,
    input  logic        send_done,
    output logic        cpu_req_ready,
    output logic        cpu_rsp_valid,
    output logic        mem_rd_req_valid,
    output logic [31:0] mem_rd_req_addr,
    output logic [7:0]  mem_rd_req_len,
    output logic        mem_rd_rsp_ready,
    output logic        mem_wr_req_valid,
    output logic [31:0] mem_wr_req_addr,
    output logic [7:0]  mem_wr_req_len,
    output logic        mem_wr_data_valid,
    output strb_t       mem_wr_data_strb,
    output set_idx_t    set_idx,
    output tag_t        tag,
    output word_idx_t   word_idx,
    output word_t       wdata,
    output strb_t       wstrb,
    output way_mask_t   sel_way,
    output logic        fill_en,
    output logic        word_wr_en,
    output logic        clean_en,
    output logic        touch_en,
    output logic        load_en,
    output logic        rx_active,
    output logic        tx_active
);

    cache_state_e state_q, state_d;

    req_op_e     op_q;
    logic [31:0] addr_q;
    word_t       wdata_q;
    strb_t       wstrb_q;
    way_mask_t   way_q;

    logic        accept;
    logic        hit;
    logic        victim_dirty;

    assign accept       = (state_q == ST_IDLE) && cpu_req_valid;
    assign hit          = |hit_mask;
    assign victim_dirty = |(victim_way & dirty_mask);

    // request latch, payload only
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= req_op_e'(cpu_req_op);
            addr_q  <= cpu_req_addr;
            wdata_q <= cpu_req_wdata;
            wstrb_q <= cpu_req_wstrb;
        end
    end

    assign tag      = addr_q[31 -: TAG_BITS];
    assign set_idx  = addr_q[OFFSET_BITS +: SET_BITS];
    assign word_idx = addr_q[2 +: OFFSET_BITS-2];
    assign wdata    = wdata_q;
    assign wstrb    = wstrb_q;

    // hit way at tag read, victim at evict
    always_ff @(posedge clk) begin
        if (rst) begin
            way_q <= '0;
        end else if (state_q == ST_TAG_READ) begin
            way_q <= hit_mask;
        end else if (state_q == ST_EVICT) begin
            way_q <= victim_way;
        end
    end

    assign sel_way = way_q;

    always_ff @(posedge clk) begin
        if (rst) state_q <= ST_IDLE;
        else     state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:        if (cpu_req_valid) state_d = ST_TAG_READ;
            ST_TAG_READ: begin
                if (!hit)                  state_d = ST_EVICT;
                else if (op_q == OP_WRITE) state_d = ST_CACHE_WRITE;
                else                       state_d = ST_CACHE_READ;
            end
            ST_CACHE_READ:  state_d = ST_RESPONSE;
            ST_EVICT:       state_d = victim_dirty ? ST_MEM_WRITE : ST_MEM_READ;
            ST_MEM_WRITE:   if (mem_wr_req_ready) state_d = ST_SEND;
            ST_SEND:        if (send_done) state_d = ST_MEM_READ;
            ST_MEM_READ:    if (mem_rd_req_ready) state_d = ST_RECEIVE;
            ST_RECEIVE:     if (mem_rd_rsp_valid && mem_rd_rsp_last) state_d = ST_REFILL;
            ST_REFILL:      state_d = (op_q == OP_WRITE) ? ST_CACHE_WRITE : ST_RESPONSE;
            ST_CACHE_WRITE: state_d = ST_IDLE;
            ST_RESPONSE:    if (cpu_rsp_ready) state_d = ST_IDLE;
            default:        state_d = ST_IDLE;
        endcase
    end

    assign cpu_req_ready     = (state_q == ST_IDLE);
    assign cpu_rsp_valid     = (state_q == ST_RESPONSE);

    // refill always fetches the whole line
    assign mem_rd_req_valid  = (state_q == ST_MEM_READ);
    assign mem_rd_req_addr   = {addr_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign mem_rd_req_len    = 8'(BURST_LEN);
    assign mem_rd_rsp_ready  = (state_q == ST_RECEIVE);

    // write-back goes to the victim's own address
    assign mem_wr_req_valid  = (state_q == ST_MEM_WRITE);
    assign mem_wr_req_addr   = {sel_tag, set_idx, {OFFSET_BITS{1'b0}}};
    assign mem_wr_req_len    = 8'(BURST_LEN);
    assign mem_wr_data_valid = (state_q == ST_SEND);
    assign mem_wr_data_strb  = '1;

    assign fill_en    = (state_q == ST_REFILL);
    assign word_wr_en = (state_q == ST_CACHE_WRITE);
    assign clean_en   = send_done;
    assign touch_en   = (state_q == ST_CACHE_WRITE) || (cpu_rsp_valid && cpu_rsp_ready);
    assign load_en    = (state_q == ST_MEM_WRITE);   // victim line stable while waiting
    assign rx_active  = (state_q == ST_RECEIVE);
    assign tx_active  = (state_q == ST_SEND);

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state_q inside {ST_IDLE, ST_TAG_READ, ST_CACHE_READ, ST_EVICT, ST_MEM_WRITE,
                        ST_SEND, ST_MEM_READ, ST_RECEIVE, ST_REFILL, ST_CACHE_WRITE,
                        ST_RESPONSE}
    );

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_geom_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // cpu request
    input  logic        cpu_req_valid,
    input  logic        cpu_req_op,
    input  logic [31:0] cpu_req_addr,
    input  word_t       cpu_req_wdata,
    input  strb_t       cpu_req_wstrb,
    output logic        cpu_req_ready,
    // cpu response
    output logic        cpu_rsp_valid,
    output word_t       cpu_rsp_data,
    input  logic        cpu_rsp_ready,
    // memory read
    output logic        mem_rd_req_valid,
    output logic [31:0] mem_rd_req_addr,
    output logic [7:0]  mem_rd_req_len,
    input  logic        mem_rd_req_ready,
    input  logic        mem_rd_rsp_valid,
    input  word_t       mem_rd_rsp_data,
    input  logic        mem_rd_rsp_last,
    output logic        mem_rd_rsp_ready,
    // memory write
    output logic        mem_wr_req_valid,
    output logic [31:0] mem_wr_req_addr,
    output logic [7:0]  mem_wr_req_len,
    input  logic        mem_wr_req_ready,
    output logic        mem_wr_data_valid,
    output word_t       mem_wr_data,
    output strb_t       mem_wr_data_strb,
    output logic        mem_wr_data_last,
    input  logic        mem_wr_data_ready
);

    set_idx_t  set_idx;
    tag_t      tag;
    word_idx_t word_idx;
    word_t     wdata;
    strb_t     wstrb;
    way_mask_t sel_way;
    way_mask_t hit_mask;
    way_mask_t valid_mask;
    way_mask_t dirty_mask;
    way_mask_t victim_way;
    line_t     sel_line;
    line_t     fill_line;
    word_t     sel_word;
    tag_t      sel_tag;
    logic      fill_en;
    logic      word_wr_en;
    logic      clean_en;
    logic      touch_en;
    logic      load_en;
    logic      rx_active;
    logic      tx_active;
    logic      send_done;

    dcache_ctrl u_ctrl (.*);

    dcache_arrays u_arrays (.*);

    dcache_plru u_plru (
        .clk        (clk),
        .rst        (rst),
        .set_idx    (set_idx),
        .valid_mask (valid_mask),
        .touch_en   (touch_en),
        .touch_way  (sel_way),
        .victim_way (victim_way)
    );

    dcache_line_buffer u_line_buffer (
        .clk               (clk),
        .rst               (rst),
        .rx_active         (rx_active),
        .mem_rd_rsp_valid  (mem_rd_rsp_valid),
        .mem_rd_rsp_data   (mem_rd_rsp_data),
        .load_en           (load_en),
        .load_line         (sel_line),   // victim line
        .tx_active         (tx_active),
        .mem_wr_data_ready (mem_wr_data_ready),
        .fill_line         (fill_line),
        .mem_wr_data       (mem_wr_data),
        .mem_wr_data_last  (mem_wr_data_last),
        .send_done         (send_done)
    );

    assign cpu_rsp_data = sel_word;

endmodule

// File: tests/dcache_mem_model.sv
`timescale 1ns/1ps

module dcache_mem_model import dcache_geom_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        rd_stall,
    input  logic        wr_stall,
    // read side
    input  logic        mem_rd_req_valid,
    input  logic [31:0] mem_rd_req_addr,
    input  logic [7:0]  mem_rd_req_len,
    output logic        mem_rd_req_ready,
    output logic        mem_rd_rsp_valid,
    output word_t       mem_rd_rsp_data,
    output logic        mem_rd_rsp_last,
    input  logic        mem_rd_rsp_ready,
    // write side
    input  logic        mem_wr_req_valid,
    input  logic [31:0] mem_wr_req_addr,
    output logic        mem_wr_req_ready,
    input  logic        mem_wr_data_valid,
    input  word_t       mem_wr_data,
    input  strb_t       mem_wr_data_strb,
    input  logic        mem_wr_data_last,
    output logic        mem_wr_data_ready
);

    word_t      mem [1024];   // 4 KiB, word addressed

    logic       rd_busy_q;
    logic [9:0] rd_ptr_q;
    logic [7:0] rd_left_q;
    logic       wr_busy_q;
    logic [9:0] wr_ptr_q;

    assign mem_rd_req_ready  = !rd_busy_q && !rd_stall;
    assign mem_rd_rsp_valid  = rd_busy_q;   // beats run back to back
    assign mem_rd_rsp_data   = mem[rd_ptr_q];
    assign mem_rd_rsp_last   = rd_busy_q && (rd_left_q == 8'd0);
    assign mem_wr_req_ready  = !wr_busy_q && !wr_stall;
    assign mem_wr_data_ready = wr_busy_q && !wr_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy_q <= 1'b0;
            wr_busy_q <= 1'b0;
            for (int i = 0; i < 1024; i++) mem[i] <= word_t'(i);   // word holds its own address
        end else begin
            if (mem_rd_req_valid && mem_rd_req_ready) begin
                rd_busy_q <= 1'b1;
                rd_ptr_q  <= mem_rd_req_addr[11:2];
                rd_left_q <= mem_rd_req_len;
            end else if (mem_rd_rsp_valid && mem_rd_rsp_ready) begin
                rd_ptr_q  <= rd_ptr_q + 10'd1;
                rd_left_q <= rd_left_q - 8'd1;
                if (mem_rd_rsp_last) rd_busy_q <= 1'b0;
            end
            if (mem_wr_req_valid && mem_wr_req_ready) begin
                wr_busy_q <= 1'b1;
                wr_ptr_q  <= mem_wr_req_addr[11:2];
            end else if (mem_wr_data_valid && mem_wr_data_ready) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_wr_data_strb[b]) mem[wr_ptr_q][b*8 +: 8] <= mem_wr_data[b*8 +: 8];
                end
                wr_ptr_q <= wr_ptr_q + 10'd1;
                if (mem_wr_data_last) wr_busy_q <= 1'b0;
            end
        end
    end

endmodule

// File: tests/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_geom_pkg::*, dcache_ctrl_pkg::*;;

    localparam int NUM_REQ        = 5 + 2 * 200 + 5;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 60 + 200;

    logic        clk, rst;
    logic        cpu_req_valid, cpu_req_op, cpu_req_ready;
    logic [31:0] cpu_req_addr;
    word_t       cpu_req_wdata, cpu_rsp_data, mem_rd_rsp_data, mem_wr_data;
    strb_t       cpu_req_wstrb, mem_wr_data_strb;
    logic        cpu_rsp_valid, cpu_rsp_ready;
    logic        mem_rd_req_valid, mem_rd_req_ready, mem_rd_rsp_valid, mem_rd_rsp_last;
    logic        mem_rd_rsp_ready, mem_wr_req_valid, mem_wr_req_ready;
    logic        mem_wr_data_valid, mem_wr_data_last, mem_wr_data_ready;
    logic [31:0] mem_rd_req_addr, mem_wr_req_addr;
    logic [7:0]  mem_rd_req_len, mem_wr_req_len;
    logic        rd_stall, wr_stall;

    logic [15:0] stim_lfsr  = 16'd53;
    logic [15:0] stall_lfsr = 16'd53;
    logic [7:0]  shadow [4096];   // byte image of memory as the cpu sees it
    word_t       exp_data_q;
    logic [31:0] last_addr_q, wb_addr_q;
    logic        last_rd_q, req_fire, repeat_hit, rd_fire, wr_fire;
    logic [2:0]  rd_beat_q, wb_beat_q;
    int          wb_count_q;

    dcache_top DUT (.*);

    dcache_mem_model mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
    endtask

    function automatic word_t shadow_word(input logic [31:0] addr);
        logic [11:0] a;
        a = {addr[11:2], 2'b00};
        return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    // ready stalls on the response and both memory sides
    always @(posedge clk) begin
        logic [5:0] r;
        for (int i = 0; i < 6; i++) begin
            stall_lfsr = lfsr_next(stall_lfsr);
            r[i] = stall_lfsr[0];
        end
        cpu_rsp_ready <= !(r[0] && r[1]);
        rd_stall      <= r[2] && r[3];
        wr_stall      <= r[4] && r[5];
    end

    assign req_fire   = cpu_req_valid && cpu_req_ready;
    assign rd_fire    = mem_rd_rsp_valid && mem_rd_rsp_ready;
    assign wr_fire    = mem_wr_data_valid && mem_wr_data_ready;
    assign repeat_hit = req_fire && (cpu_req_op == OP_READ) && last_rd_q
                        && (last_addr_q == cpu_req_addr);

    // shadow memory and bus bookkeeping
    always @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < 4096; a++) shadow[a] <= 8'((a >> 2) >> (8 * (a % 4)));
            last_rd_q  <= 1'b0;
            rd_beat_q  <= '0;
            wb_beat_q  <= '0;
            wb_count_q <= 0;
        end else begin
            if (req_fire) begin
                last_rd_q   <= (cpu_req_op == OP_READ);
                last_addr_q <= cpu_req_addr;
                if (cpu_req_op == OP_READ) exp_data_q <= shadow_word(cpu_req_addr);
                for (int b = 0; b < 4; b++) begin
                    if (cpu_req_op == OP_WRITE && cpu_req_wstrb[b])
                        shadow[{cpu_req_addr[11:2], 2'(b)}] <= cpu_req_wdata[b*8 +: 8];
                end
            end
            if (rd_fire) rd_beat_q <= rd_beat_q + 3'd1;
            if (mem_wr_req_valid && mem_wr_req_ready) wb_addr_q <= mem_wr_req_addr;
            if (wr_fire) begin
                wb_beat_q <= wb_beat_q + 3'd1;   // wraps after eight beats
                if (mem_wr_data_last) wb_count_q <= wb_count_q + 1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> cpu_req_ready
        && !cpu_rsp_valid && !mem_rd_req_valid && !mem_rd_rsp_ready && !mem_wr_req_valid
        && !mem_wr_data_valid)
        else report_error("outputs were not idle after reset");

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_valid && cpu_rsp_ready |-> cpu_rsp_data == exp_data_q)
        else report_error($sformatf("mismatch cpu_rsp_data got %h expected %h",
                                    $sampled(cpu_rsp_data), $sampled(exp_data_q)));

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        repeat_hit |=> !cpu_rsp_valid ##1 !cpu_rsp_valid ##1 cpu_rsp_valid)
        else report_error("repeated read did not respond 3 cycles after acceptance");

    a_rd_req: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req_valid |-> mem_rd_req_addr[4:0] == 5'd0 && mem_rd_req_len == 8'd7)
        else report_error($sformatf("mismatch mem_rd_req addr %h len %h",
                                    $sampled(mem_rd_req_addr), $sampled(mem_rd_req_len)));

    // the cache keeps taking beats until the eighth, then stops
    a_rd_beats: assert property (@(posedge clk) disable iff (rst)
        rd_fire |=> mem_rd_rsp_ready == (rd_beat_q != 3'd0))
        else report_error("refill burst did not take exactly 8 beats");

    a_wr_req: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req_valid |-> mem_wr_req_addr[4:0] == 5'd0 && mem_wr_req_len == 8'd7)
        else report_error($sformatf("mismatch mem_wr_req addr %h len %h",
                                    $sampled(mem_wr_req_addr), $sampled(mem_wr_req_len)));

    a_wr_last: assert property (@(posedge clk) disable iff (rst)
        wr_fire |-> mem_wr_data_last == (wb_beat_q == 3'd7))
        else report_error("mem_wr_data_last was not on the eighth write-back beat");

    a_wr_strb: assert property (@(posedge clk) disable iff (rst)
        wr_fire |-> mem_wr_data_strb == 4'hF)
        else report_error($sformatf("mismatch mem_wr_data_strb got %h expected f",
                                    $sampled(mem_wr_data_strb)));

    a_wr_data: assert property (@(posedge clk) disable iff (rst)
        wr_fire |-> mem_wr_data == shadow_word(wb_addr_q + {wb_beat_q, 2'b00}))
        else report_error($sformatf("mismatch mem_wr_data got %h expected %h",
            $sampled(mem_wr_data), shadow_word(wb_addr_q + {wb_beat_q, 2'b00})));

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_valid && !cpu_rsp_ready |=> cpu_rsp_valid && $stable(cpu_rsp_data))
        else report_error("cpu response changed while stalled");

    task automatic send_request(input req_op_e op, input logic [31:0] addr,
                                input word_t data, input strb_t strb);
        @(posedge clk);
        cpu_req_valid <= 1'b1;
        cpu_req_op    <= op;
        cpu_req_addr  <= addr;
        cpu_req_wdata <= data;
        cpu_req_wstrb <= strb;
        do @(negedge clk); while (!cpu_req_ready);
        @(posedge clk);
        cpu_req_valid <= 1'b0;
        if (op == OP_READ) begin
            do @(negedge clk); while (!(cpu_rsp_valid && cpu_rsp_ready));
        end
    endtask

    initial begin
        logic [31:0] v, addr, data;
        req_op_e     op;
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req_op    = 1'b0;
        cpu_req_addr  = '0;
        cpu_req_wdata = '0;
        cpu_req_wstrb = '0;
        cpu_rsp_ready = 1'b0;
        rd_stall      = 1'b0;
        wr_stall      = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // five lines into set 3 force a dirty eviction
        for (int k = 0; k < 5; k++) begin
            rand_bits(32, data);
            send_request(OP_WRITE, 32'(k * 256 + 32'h60), data, 4'hF);
        end
        do @(negedge clk); while (!cpu_req_ready);
        if (wb_count_q == 0) begin
            report_error("five writes into one set caused no write-back");
        end
        for (int n = 0; n < 200; n++) begin
            rand_bits(8, v);
            addr = {20'd0, v[7:4], 2'b00, v[3], v[2:0], 2'b00};   // two sets, sixteen tags
            rand_bits(1, v);
            op = req_op_e'(v[0]);
            rand_bits(32, data);
            rand_bits(4, v);
            send_request(op, addr, data, v[3:0]);
            if (op == OP_READ) send_request(OP_READ, addr, '0, '0);
        end
        for (int k = 0; k < 5; k++) send_request(OP_READ, 32'(k * 256 + 32'h60), '0, '0);
        do @(negedge clk); while (!cpu_req_ready);   // last response has completed
        $display("test passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * 4);
        report_error("timeout, the cache stopped answering");
    end

endmodule

// File: files.f
logic/dcache_geom_pkg.sv
logic/dcache_ctrl_pkg.sv
logic/dcache_arrays.sv
logic/dcache_plru.sv
logic/dcache_line_buffer.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

// File: Makefile
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: obj_dir/Vdcache_tb

obj_dir/Vdcache_tb: files.f $(SRCS)
	verilator --binary --timing --assert --top-module dcache_tb -f files.f -o Vdcache_tb

run: obj_dir/Vdcache_tb
	./obj_dir/Vdcache_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "test failed" sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
